// ==== rtl/cnode_engine.sv ====
// normalized min-sum check-node engine, one row of COLS vnodes, two stages
module cnode_engine import ldpc_dec_pkg::*; #(
  parameter int COLS        = 6,
  parameter int NODE_W      = ldpc_dec_pkg::NODE_W,
  parameter int NORM_FACTOR = 6  // scale = NORM_FACTOR/8
) (
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     iclkena,
  input  logic                     ival,
  input  logic                     isof,
  input  logic                     ieof,
  input  logic                     ivmask [COLS],
  input  logic signed [NODE_W-1:0] ivnode [COLS],
  output logic                     oval,
  output logic                     osof,
  output logic                     oeof,
  output logic signed [NODE_W-1:0] ocnode [COLS],
  output logic                     orowfail
);

  localparam int MAG_W   = NODE_W - 1;
  localparam int MAG_MAX = (1 << MAG_W) - 1;  // saturation max
  localparam int IDX_W   = (COLS > 1) ? $clog2(COLS) : 1;

  int   c_min1;
  int   c_min2;
  int   c_idx;
  int   c_mag;
  logic c_prod;  // xor of unmasked signs

  logic             s1_val;
  logic             s1_sof;
  logic             s1_eof;
  logic             s1_mask [COLS];
  logic             s1_sgn  [COLS];
  logic             s1_prod;
  logic [MAG_W-1:0] s1_min1;
  logic [MAG_W-1:0] s1_min2;
  logic [IDX_W-1:0] s1_idx;

  int                       c_scl;
  logic signed [NODE_W-1:0] c_cnode [COLS];

  // ----------------------------------------------------------
  // stage 1: sign product, two smallest magnitudes, min1 position
  always_comb begin
    c_min1 = MAG_MAX;  // lone column sees saturation max
    c_min2 = MAG_MAX;
    c_idx  = 0;
    c_mag  = 0;
    c_prod = 1'b0;
    for (int j = 0; j < COLS; j++) begin
      c_mag = mag_of(int'(ivnode[j]));
      if (!ivmask[j]) begin
        c_prod = c_prod ^ ivnode[j][NODE_W-1];
        if (c_mag < c_min1) begin
          c_min2 = c_min1;
          c_min1 = c_mag;
          c_idx  = j;
        end else if (c_mag < c_min2) begin
          c_min2 = c_mag;  // ties land here
        end
      end
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      s1_val <= 1'b0;
      s1_sof <= 1'b0;
      s1_eof <= 1'b0;
    end else if (iclkena) begin
      s1_val <= ival;
      s1_sof <= ival & isof;
      s1_eof <= ival & ieof;
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      for (int j = 0; j < COLS; j++) begin
        s1_mask[j] <= ivmask[j];
        s1_sgn[j]  <= ivnode[j][NODE_W-1];
      end
      s1_prod <= c_prod;
      s1_min1 <= MAG_W'(c_min1);
      s1_min2 <= MAG_W'(c_min2);
      s1_idx  <= IDX_W'(c_idx);
    end
  end

  // ----------------------------------------------------------
  // stage 2: extrinsic min, scale, extrinsic sign
  always_comb begin
    c_scl = 0;
    for (int j = 0; j < COLS; j++) begin
      c_scl = ((j == int'(s1_idx)) ? int'(s1_min2) : int'(s1_min1)) * NORM_FACTOR;
      c_scl = c_scl >>> 3;
      if (s1_mask[j]) begin
        c_cnode[j] = '0;
      end else if (s1_prod ^ s1_sgn[j]) begin  // own sign removed
        c_cnode[j] = NODE_W'(-c_scl);
      end else begin
        c_cnode[j] = NODE_W'(c_scl);
      end
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval <= 1'b0;
      osof <= 1'b0;
      oeof <= 1'b0;
    end else if (iclkena) begin
      oval <= s1_val;
      osof <= s1_sof;
      oeof <= s1_eof;
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      ocnode   <= c_cnode;
      orowfail <= s1_prod;  // odd parity on the row
    end
  end

endmodule

// ==== rtl/cnode_msg_buffer.sv ====
// check-message memory, one COLS-wide vector per row, registered read port
module cnode_msg_buffer #(
  parameter int  COLS   = 6,
  parameter int  ROWS   = 8,
  parameter int  NODE_W = ldpc_dec_pkg::NODE_W,
  localparam int ROW_W  = (ROWS > 1) ? $clog2(ROWS) : 1
) (
  input  logic                     iclk,
  input  logic                     wr_en,
  input  logic [ROW_W-1:0]         wr_row,
  input  logic signed [NODE_W-1:0] wr_msg [COLS],
  input  logic [ROW_W-1:0]         rd_row,
  output logic signed [NODE_W-1:0] rd_msg [COLS]
);

  logic signed [NODE_W-1:0] mem [ROWS][COLS];  // stale on first pass, feeder ignores it

  // ----------------------------------------------------------
  // write-back from the unit output, read for the feeder
  always_ff @(posedge iclk) begin
    for (int j = 0; j < COLS; j++) begin
      if (wr_en) begin
        mem[wr_row][j] <= wr_msg[j];
      end
      rd_msg[j] <= mem[rd_row][j];  // 1 cycle read latency
    end
  end

endmodule

// ==== rtl/cnode_unit.sv ====
// check-node unit: engine, output register, row counter, busy FSM, block decode-fail
module cnode_unit import ldpc_dec_pkg::*; #(
  parameter int  COLS        = 6,
  parameter int  ROWS        = 8,
  parameter int  NODE_W      = ldpc_dec_pkg::NODE_W,
  parameter int  NORM_FACTOR = 6,
  localparam int ROW_W       = (ROWS > 1) ? $clog2(ROWS) : 1
) (
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     iclkena,
  input  logic                     ival,
  input  logic                     isof,
  input  logic                     ieof,
  input  logic                     ivmask [COLS],
  input  logic signed [NODE_W-1:0] ivnode [COLS],
  output logic                     oval,
  output logic                     osof,
  output logic                     oeof,
  output logic [ROW_W-1:0]         orow,
  output logic signed [NODE_W-1:0] ocnode [COLS],
  output logic                     odecfail,
  output logic                     obusy
);

  logic                     e_val;
  logic                     e_sof;
  logic                     e_eof;
  logic                     e_rowfail;
  logic signed [NODE_W-1:0] e_cnode [COLS];
  unit_state_t              state;

  cnode_engine #(
    .COLS        (COLS),
    .NODE_W      (NODE_W),
    .NORM_FACTOR (NORM_FACTOR)
  ) i_engine (
    .iclk     (iclk),
    .ireset   (ireset),
    .iclkena  (iclkena),
    .ival     (ival),
    .isof     (isof),
    .ieof     (ieof),
    .ivmask   (ivmask),
    .ivnode   (ivnode),
    .oval     (e_val),
    .osof     (e_sof),
    .oeof     (e_eof),
    .ocnode   (e_cnode),
    .orowfail (e_rowfail)
  );

  // ----------------------------------------------------------
  // output strobes, row count, fail accumulate, busy FSM
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval     <= 1'b0;
      osof     <= 1'b0;
      oeof     <= 1'b0;
      orow     <= '0;
      odecfail <= 1'b0;
      state    <= ST_IDLE;
    end else if (iclkena) begin
      oval <= e_val;
      osof <= e_val & e_sof;
      oeof <= e_val & e_eof;
      if (e_val) begin
        orow     <= e_sof ? '0 : orow + 1'b1;
        odecfail <= e_rowfail | (odecfail & ~e_sof);  // restart on sof
      end
      case (state)
        ST_IDLE: if (e_val & e_sof) state <= ST_BUSY;
        // drop after last row unless next block starts right away
        ST_BUSY: if (oval & oeof & ~(e_val & e_sof)) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign obusy = (state == ST_BUSY);

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      ocnode <= e_cnode;
    end
  end

endmodule

// ==== rtl/ldpc_check_layer_top.sv ====
// check layer top: vnode feeder, check-message buffer and check-node unit
module ldpc_check_layer_top #(
  parameter int  COLS        = 6,
  parameter int  ROWS        = 8,  // at least 6, write-back vs next read
  parameter int  NORM_FACTOR = 6,
  parameter int  LLR_W       = ldpc_dec_pkg::LLR_W,
  parameter int  NODE_W      = ldpc_dec_pkg::NODE_W,
  localparam int ROW_W       = (ROWS > 1) ? $clog2(ROWS) : 1
) (
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     iclkena,
  input  logic                     ival,
  input  logic                     isof,
  input  logic                     ieof,
  input  logic                     ifirst,
  input  logic                     imask  [COLS],
  input  logic signed [LLR_W-1:0]  illr   [COLS],
  output logic                     oval,
  output logic                     osof,
  output logic                     oeof,
  output logic [ROW_W-1:0]         orow,
  output logic signed [NODE_W-1:0] ocnode [COLS],
  output logic                     odecfail,
  output logic                     obusy
);

  logic [ROW_W-1:0]         rd_row;
  logic signed [NODE_W-1:0] rd_msg [COLS];
  logic                     fval;
  logic                     fsof;
  logic                     feof;
  logic                     fmask  [COLS];
  logic signed [NODE_W-1:0] fvnode [COLS];

  // ----------------------------------------------------------
  vnode_feeder #(
    .COLS   (COLS),
    .ROWS   (ROWS),
    .LLR_W  (LLR_W),
    .NODE_W (NODE_W)
  ) i_feeder (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .ival    (ival),
    .isof    (isof),
    .ieof    (ieof),
    .ifirst  (ifirst),
    .imask   (imask),
    .illr    (illr),
    .rd_row  (rd_row),
    .rd_msg  (rd_msg),
    .fval    (fval),
    .fsof    (fsof),
    .feof    (feof),
    .fmask   (fmask),
    .fvnode  (fvnode)
  );

  // write port fed straight from the unit output beat
  cnode_msg_buffer #(
    .COLS   (COLS),
    .ROWS   (ROWS),
    .NODE_W (NODE_W)
  ) i_buffer (
    .iclk   (iclk),
    .wr_en  (oval),
    .wr_row (orow),
    .wr_msg (ocnode),
    .rd_row (rd_row),
    .rd_msg (rd_msg)
  );

  cnode_unit #(
    .COLS        (COLS),
    .ROWS        (ROWS),
    .NODE_W      (NODE_W),
    .NORM_FACTOR (NORM_FACTOR)
  ) i_unit (
    .iclk     (iclk),
    .ireset   (ireset),
    .iclkena  (iclkena),
    .ival     (fval),
    .isof     (fsof),
    .ieof     (feof),
    .ivmask   (fmask),
    .ivnode   (fvnode),
    .oval     (oval),
    .osof     (osof),
    .oeof     (oeof),
    .orow     (orow),
    .ocnode   (ocnode),
    .odecfail (odecfail),
    .obusy    (obusy)
  );

endmodule

// ==== rtl/ldpc_dec_pkg.sv ====
// default widths, check-node unit state enum, saturate and magnitude helpers
package ldpc_dec_pkg;

  parameter int LLR_W  = 4;  // channel llr width
  parameter int NODE_W = 5;  // signed vnode / cnode message width

  // check-node unit state
  typedef enum logic {
    ST_IDLE,
    ST_BUSY
  } unit_state_t;

  // ----------------------------------------------------------
  // clamp to +/-(2^(w-1)-1), the negative extreme never shows up
  function automatic int sat_node(input int v, input int w);
    int lim;
    lim = (1 << (w - 1)) - 1;
    if (v > lim) return lim;
    if (v < -lim) return -lim;
    return v;
  endfunction

  // abs of a message, safe since sat_node keeps it symmetric
  function automatic int mag_of(input int v);
    return (v < 0) ? -v : v;
  endfunction

endpackage

// ==== rtl/vnode_feeder.sv ====
// vnode feeder: row tracking, stored message read, llr align and saturated subtract
module vnode_feeder import ldpc_dec_pkg::*; #(
  parameter int  COLS   = 6,
  parameter int  ROWS   = 8,
  parameter int  LLR_W  = ldpc_dec_pkg::LLR_W,
  parameter int  NODE_W = ldpc_dec_pkg::NODE_W,
  localparam int ROW_W  = (ROWS > 1) ? $clog2(ROWS) : 1
) (
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     iclkena,
  input  logic                     ival,
  input  logic                     isof,
  input  logic                     ieof,
  input  logic                     ifirst,     // stored messages taken as zero
  input  logic                     imask  [COLS],
  input  logic signed [LLR_W-1:0]  illr   [COLS],
  output logic [ROW_W-1:0]         rd_row,
  input  logic signed [NODE_W-1:0] rd_msg [COLS],
  output logic                     fval,
  output logic                     fsof,
  output logic                     feof,
  output logic                     fmask  [COLS],
  output logic signed [NODE_W-1:0] fvnode [COLS]
);

  localparam int SHIFT = NODE_W - LLR_W;  // fixed point align

  logic [ROW_W-1:0]        row_cnt;  // next expected row
  logic [ROW_W-1:0]        row_q;    // row of the registered beat
  logic                    val_q;
  logic                    sof_q;
  logic                    eof_q;
  logic                    first_q;
  logic                    mask_q [COLS];
  logic signed [LLR_W-1:0] llr_q  [COLS];
  logic signed [NODE_W-1:0] vnode_c [COLS];

  // read address of the incoming beat, held on the old row while stalled
  assign rd_row = !iclkena ? row_q : (isof ? '0 : row_cnt);

  // ----------------------------------------------------------
  // cycle 1: register beat, step row, read issued via rd_row
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_q   <= 1'b0;
      sof_q   <= 1'b0;
      eof_q   <= 1'b0;
      row_cnt <= '0;
      row_q   <= '0;
    end else if (iclkena) begin
      val_q <= ival;
      sof_q <= ival & isof;
      eof_q <= ival & ieof;
      row_q <= rd_row;
      if (ival) begin
        row_cnt <= ieof ? '0 : rd_row + 1'b1;  // wrap at block end
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      first_q <= ifirst;
      mask_q  <= imask;
      llr_q   <= illr;
    end
  end

  // cycle 2: llr << SHIFT minus stored cnode, saturated
  always_comb begin
    for (int j = 0; j < COLS; j++) begin
      if (mask_q[j]) begin
        vnode_c[j] = '0;  // column not in this row
      end else begin
        vnode_c[j] = NODE_W'(sat_node((int'(llr_q[j]) <<< SHIFT) -
                                      (first_q ? 0 : int'(rd_msg[j])), NODE_W));
      end
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      fval <= 1'b0;
      fsof <= 1'b0;
      feof <= 1'b0;
    end else if (iclkena) begin
      fval <= val_q;
      fsof <= sof_q;
      feof <= eof_q;
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      fmask  <= mask_q;
      fvnode <= vnode_c;
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the check layer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ldpc_check_layer -f src.f -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
  echo "simulation ok"
else
  echo "simulation reported a failure"
  exit 1
fi

// ==== sim/ldpc_check_layer_checker.sv ====
// concurrent assertions on the check layer outputs, bound to the top level
module ldpc_check_layer_checker (
  input logic iclk,
  input logic ireset,
  input logic oval,
  input logic osof,
  input logic obusy,
  input logic odecfail
);
  timeunit 1ns;
  timeprecision 1ps;

  // outputs quiet while reset is held
  reset_quiet: assert property (@(posedge iclk) ireset |-> (!oval && !obusy && !odecfail))
    else $error("output strobe or flag active during reset");

  sof_with_val: assert property (@(posedge iclk) disable iff (ireset) osof |-> oval)
    else $error("osof seen without oval");

  // rows after the first of a block keep the unit busy
  busy_on_rows: assert property (@(posedge iclk) disable iff (ireset)
                                 (oval && !osof) |-> obusy)
    else $error("obusy low on an output row");

endmodule

bind ldpc_check_layer_top ldpc_check_layer_checker i_checker (
  .iclk     (iclk),
  .ireset   (ireset),
  .oval     (oval),
  .osof     (osof),
  .obusy    (obusy),
  .odecfail (odecfail)
);

// ==== sim/tb_ldpc_check_layer.sv ====
// testbench: clock, reset, random row blocks, reference model, output checks
module tb_ldpc_check_layer;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int COLS        = 6;
  localparam int ROWS        = 8;
  localparam int NORM        = 6;
  localparam int LLR_W       = 4;
  localparam int NODE_W      = 5;
  localparam int ROW_W       = $clog2(ROWS);
  localparam int MAG_MAX     = (1 << (NODE_W - 1)) - 1;  // symmetric message limit
  localparam int DRAIN_LIMIT = 300;                      // cycles to wait for the pipe

  // block stimulus kinds
  localparam int MODE_RAND   = 0;
  localparam int MODE_KEEP   = 1;  // replay last random block
  localparam int MODE_SPARSE = 2;
  localparam int MODE_POS    = 3;
  localparam int MODE_ODD    = 4;

  typedef struct packed {
    logic [COLS*NODE_W-1:0] cnode;
    logic [ROW_W-1:0]       row;
    logic                   sof;
    logic                   eof;
    logic                   fail;  // block decode-fail so far
  } exp_t;

  logic                     iclk;
  logic                     ireset;
  logic                     iclkena;
  logic                     ival;
  logic                     isof;
  logic                     ieof;
  logic                     ifirst;
  logic                     imask  [COLS];
  logic signed [LLR_W-1:0]  illr   [COLS];
  logic                     oval;
  logic                     osof;
  logic                     oeof;
  logic [ROW_W-1:0]         orow;
  logic signed [NODE_W-1:0] ocnode [COLS];
  logic                     odecfail;
  logic                     obusy;

  // reference model state
  int   mem_model [ROWS][COLS];  // stored check messages per row
  int   llr_keep  [ROWS][COLS];
  bit   mask_keep [ROWS][COLS];
  int   cur_llr   [COLS];
  bit   cur_mask  [COLS];
  bit   blk_fail;
  exp_t exp_q [$];

  int   errors       = 0;
  int   beats        = 0;
  int   tests_run    = 0;
  int   tests_failed = 0;
  bit   timed_out    = 1'b0;
  bit   blk_open     = 1'b0;  // between osof and oeof beats
  bit   eof_seen     = 1'b0;  // last enabled cycle carried oeof
  logic last_decfail = 1'b0;

  ldpc_check_layer_top #(
    .COLS        (COLS),
    .ROWS        (ROWS),
    .NORM_FACTOR (NORM),
    .LLR_W       (LLR_W),
    .NODE_W      (NODE_W)
  ) i_dut (
    .iclk     (iclk),
    .ireset   (ireset),
    .iclkena  (iclkena),
    .ival     (ival),
    .isof     (isof),
    .ieof     (ieof),
    .ifirst   (ifirst),
    .imask    (imask),
    .illr     (illr),
    .oval     (oval),
    .osof     (osof),
    .oeof     (oeof),
    .orow     (orow),
    .ocnode   (ocnode),
    .odecfail (odecfail),
    .obusy    (obusy)
  );

  initial begin
    iclk = 1'b0;
    forever #4 iclk = ~iclk;  // 8 ns period
  end

  // ------------------------------------------------------------
  // reference model
  function automatic int clamp_node(input int v);
    if (v > MAG_MAX) return MAG_MAX;
    if (v < -MAG_MAX) return -MAG_MAX;
    return v;
  endfunction

  task automatic model_row(input int r, input bit first, input bit sof, input bit eof);
    int   vn [COLS];
    int   others;
    int   mg;
    int   mk;
    bit   par;
    bit   neg;
    exp_t e;
    par = 1'b0;
    for (int j = 0; j < COLS; j++) begin
      // llr scaled to node width, stored message taken off
      vn[j] = cur_mask[j] ? 0 :
              clamp_node(cur_llr[j] * (1 << (NODE_W - LLR_W)) - (first ? 0 : mem_model[r][j]));
      if (!cur_mask[j] && vn[j] < 0) par = ~par;
    end
    e.cnode = '0;
    for (int j = 0; j < COLS; j++) begin
      others = MAG_MAX;  // lone column
      for (int k = 0; k < COLS; k++) begin
        mk = (vn[k] < 0) ? -vn[k] : vn[k];
        if (k != j && !cur_mask[k] && mk < others) others = mk;
      end
      neg = par ^ (vn[j] < 0);           // sign of the other columns
      mg  = cur_mask[j] ? 0 : (others * NORM) / 8;
      mem_model[r][j] = neg ? -mg : mg;
      e.cnode[j*NODE_W +: NODE_W] = NODE_W'(mem_model[r][j]);
    end
    blk_fail = sof ? par : (blk_fail | par);
    e.row  = ROW_W'(r);
    e.sof  = sof;
    e.eof  = eof;
    e.fail = blk_fail;
    exp_q.push_back(e);
  endtask

  // ------------------------------------------------------------
  // stimulus, all on the falling edge
  task automatic drive_beat(input int r, input bit first, input bit stall);
    int tries;
    tries = 0;
    do begin
      @(negedge iclk);
      tries++;
      iclkena = (stall && tries < 20 && ($urandom % 3 == 0)) ? 1'b0 : 1'b1;
      ival    = 1'b1;
      isof    = (r == 0);
      ieof    = (r == ROWS - 1);
      ifirst  = first;
      for (int j = 0; j < COLS; j++) begin
        imask[j] = cur_mask[j];
        illr[j]  = LLR_W'(cur_llr[j]);
      end
    end while (!iclkena);  // beat held until taken
    model_row(r, first, r == 0, r == ROWS - 1);
  endtask

  task automatic idle_cycles(input int n, input bit stall);
    repeat (n) begin
      @(negedge iclk);
      iclkena = (stall && ($urandom % 3 == 0)) ? 1'b0 : 1'b1;
      ival    = 1'b0;
      isof    = 1'b0;
      ieof    = 1'b0;
    end
  endtask

  task automatic send_block(input int mode, input bit first, input bit stall);
    int odd_row;
    int odd_col;
    odd_row = $urandom % ROWS;
    odd_col = $urandom % COLS;
    for (int r = 0; r < ROWS; r++) begin
      for (int j = 0; j < COLS; j++) begin
        case (mode)
          MODE_KEEP: begin
            cur_llr[j]  = llr_keep[r][j];
            cur_mask[j] = mask_keep[r][j];
          end
          MODE_SPARSE: begin
            cur_llr[j]  = int'($urandom % 16) - 8;
            cur_mask[j] = (r == 1) || (j != r % COLS);  // row 1 fully masked
          end
          MODE_POS, MODE_ODD: begin
            cur_llr[j]  = 1 + int'($urandom % 7);
            cur_mask[j] = ($urandom % 4 == 0);
            if (mode == MODE_ODD && r == odd_row && j == odd_col) begin
              cur_llr[j]  = -1 - int'($urandom % 8);  // single negative, odd parity
              cur_mask[j] = 1'b0;
            end
          end
          default: begin
            cur_llr[j]      = int'($urandom % 16) - 8;
            cur_mask[j]     = ($urandom % 4 == 0);
            llr_keep[r][j]  = cur_llr[j];
            mask_keep[r][j] = cur_mask[j];
          end
        endcase
      end
      drive_beat(r, first, stall);
    end
  endtask

  task automatic wait_drain();
    int cyc;
    cyc = 0;
    while (exp_q.size() != 0 && cyc < DRAIN_LIMIT) begin
      @(negedge iclk);
      iclkena = 1'b1;
      ival    = 1'b0;
      isof    = 1'b0;
      ieof    = 1'b0;
      cyc++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d expected output rows never came out", exp_q.size());
      errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("[FAIL] %s = %0h, expected %0h", sig, got, want);
    errors++;
  endtask

  // ------------------------------------------------------------
  // output monitor, only enabled cycles carry beats
  always @(posedge iclk) begin : check_outputs
    exp_t e;
    if (!ireset && iclkena) begin
      if (oval) begin
        beats++;
        if (obusy !== 1'b1) report_mismatch("obusy", 32'(obusy), 32'd1);
        if (exp_q.size() == 0) begin
          $display("output row %0d arrived with no row expected", orow);
          errors++;
        end else begin
          e = exp_q.pop_front();
          if (orow !== e.row) report_mismatch("orow", 32'(orow), 32'(e.row));
          if (osof !== e.sof) report_mismatch("osof", 32'(osof), 32'(e.sof));
          if (oeof !== e.eof) report_mismatch("oeof", 32'(oeof), 32'(e.eof));
          for (int j = 0; j < COLS; j++) begin
            if (ocnode[j] !== e.cnode[j*NODE_W +: NODE_W]) begin
              report_mismatch($sformatf("ocnode[%0d] row %0d", j, e.row),
                              32'(unsigned'(ocnode[j])), 32'(e.cnode[j*NODE_W +: NODE_W]));
            end
          end
          if (e.eof) begin
            last_decfail = odecfail;
            if (odecfail !== e.fail) report_mismatch("odecfail", 32'(odecfail), 32'(e.fail));
          end
        end
        if (osof) blk_open = 1'b1;
        if (oeof) blk_open = 1'b0;
      end else if (eof_seen && obusy !== 1'b0) begin
        report_mismatch("obusy", 32'(obusy), 32'd0);  // should drop after last row
      end else if (blk_open && obusy !== 1'b1) begin
        report_mismatch("obusy", 32'(obusy), 32'd1);
      end
      eof_seen = oval && oeof;
    end
  end

  // ------------------------------------------------------------
  task automatic run_test(input int num);
    int    err0;
    int    b0;
    string name;
    err0 = errors;
    b0   = beats;
    case (num)
      1: begin
        name = "first pass";
        send_block(MODE_RAND, 1'b1, 1'b0);
      end
      2: begin
        name = "second pass";
        send_block(MODE_KEEP, 1'b0, 1'b0);
      end
      3: begin
        name = "sparse masks";
        send_block(MODE_SPARSE, 1'b1, 1'b0);
      end
      4: begin
        name = "decode fail";
        send_block(MODE_POS, 1'b1, 1'b0);
        wait_drain();
        if (last_decfail !== 1'b0) report_mismatch("odecfail", 32'(last_decfail), 32'd0);
        send_block(MODE_ODD, 1'b1, 1'b0);
        wait_drain();
        if (last_decfail !== 1'b1) report_mismatch("odecfail", 32'(last_decfail), 32'd1);
        send_block(MODE_RAND, 1'b0, 1'b0);
        send_block(MODE_RAND, 1'b1, 1'b0);
      end
      5: begin
        name = "clock enable stalls";
        idle_cycles(4, 1'b1);
        send_block(MODE_RAND, 1'b0, 1'b1);
        send_block(MODE_KEEP, 1'b0, 1'b1);
      end
      default: begin
        name = "back to back blocks";
        send_block(MODE_RAND, 1'b0, 1'b0);
        send_block(MODE_RAND, 1'b0, 1'b0);
      end
    endcase
    wait_drain();
    idle_cycles(3, 1'b0);  // lets obusy fall
    if (num == 6 && beats - b0 != 2 * ROWS) begin
      report_mismatch("oval beat count", 32'(beats - b0), 32'(2 * ROWS));
    end
    tests_run++;
    if (errors != err0) tests_failed++;
    $display("test %0d %s: %0d errors", num, name, errors - err0);
  endtask

  initial begin : main
    void'($urandom(52));
    ireset  = 1'b0;
    iclkena = 1'b1;
    ival    = 1'b0;
    isof    = 1'b0;
    ieof    = 1'b0;
    ifirst  = 1'b1;
    for (int j = 0; j < COLS; j++) begin
      imask[j] = 1'b0;
      illr[j]  = '0;
    end
    #1 ireset = 1'b1;
    repeat (10) @(posedge iclk);
    @(negedge iclk);
    ireset = 1'b0;
    for (int t = 1; t <= 6 && !timed_out; t++) begin
      run_test(t);
    end
    $display("summary: %0d tests, %0d with errors, %0d output rows, %0d errors",
             tests_run, tests_failed, beats, errors);
    if (errors == 0 && !timed_out) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== src.f ====
rtl/ldpc_dec_pkg.sv
rtl/cnode_msg_buffer.sv
rtl/vnode_feeder.sv
rtl/cnode_engine.sv
rtl/cnode_unit.sv
rtl/ldpc_check_layer_top.sv
sim/ldpc_check_layer_checker.sv
sim/tb_ldpc_check_layer.sv
